// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module vex_tb -f vex.f -o vex_sim
./obj_dir/vex_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTS PASSED" sim.log; then
    exit 0
else
    exit 1
fi

// File: sim/vex_cases.txt
# name op vl mask a0..a7 b0..b7 en r0..r7 dst ticket, all hex but the name
# op: 0 add 1 sub 2 and 3 or 4 xor 5 minu 6 maxu 7 redsum
add_full 0 8 ff 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 ff 11 22 33 44 55 66 77 88 01 00
sub_full 1 8 ff 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 ff f 1e 2d 3c 4b 5a 69 78 02 01
sub_neg 1 8 ff 1 2 3 4 5 6 7 8 10 20 30 40 50 60 70 80 ff
    fffffff1 ffffffe2 ffffffd3 ffffffc4 ffffffb5 ffffffa6 ffffff97 ffffff88 03 02
add_wrap 0 8 ff ffffffff 80000000 1 7fffffff 0 0 0 0 1 80000000 ffffffff 1 0 0 0 0 ff
    0 0 0 80000000 0 0 0 0 04 03
sub_wrap 1 8 ff ffffffff 80000000 1 7fffffff 0 0 0 0 1 80000000 ffffffff 1 0 0 0 0 ff
    fffffffe 0 2 7ffffffe 0 0 0 0 05 04
and_full 2 8 ff f0 0f ff aa 55 33 cc 3c 3c 3c 0f 55 ff f0 0f c3 ff 30 0c 0f 0 55 30 0c 0 06 05
or_full 3 8 ff f0 0f ff aa 55 33 cc 3c 3c 3c 0f 55 ff f0 0f c3 ff fc 3f ff ff ff f3 cf ff 07 06
xor_full 4 8 ff f0 0f ff aa 55 33 cc 3c 3c 3c 0f 55 ff f0 0f c3 ff cc 33 f0 ff aa c3 c3 ff 08 07
minu_full 5 8 ff 5 ffffffff 7 0 80000000 9 1 64 9 1 7 3 7fffffff 2 ffffffff 63 ff
    5 1 7 0 7fffffff 2 1 63 09 08
maxu_full 6 8 ff 5 ffffffff 7 0 80000000 9 1 64 9 1 7 3 7fffffff 2 ffffffff 63 ff
    9 ffffffff 7 3 80000000 9 ffffffff 64 0a 09
redsum_full 7 8 ff 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 01 241 0 0 0 0 0 0 0 0b 0a
add_mask 0 8 a5 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 a5 11 0 33 0 0 66 0 88 0c 0b
add_vl5 0 5 ff 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 1f 11 22 33 44 55 0 0 0 0d 0c
add_vl3 0 3 f6 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 06 0 22 33 0 0 0 0 0 0e 0d
add_vl0 0 0 ff 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 00 0 0 0 0 0 0 0 0 0f 0e
xor_mask 4 8 5a f0 0f ff aa 55 33 cc 3c 3c 3c 0f 55 ff f0 0f c3 5a 0 33 0 ff aa 0 c3 0 10 0f
minu_part 5 6 7d 5 ffffffff 7 0 80000000 9 1 64 9 1 7 3 7fffffff 2 ffffffff 63 3d
    5 0 7 0 7fffffff 2 0 0 11 10
maxu_vl4 6 4 ff 5 ffffffff 7 0 80000000 9 1 64 9 1 7 3 7fffffff 2 ffffffff 63 0f
    9 ffffffff 7 3 0 0 0 0 12 11
or_vl7 3 7 ff f0 0f ff aa 55 33 cc 3c 3c 3c 0f 55 ff f0 0f c3 7f fc 3f ff ff ff f3 cf 0 13 12
redsum_mask 7 8 0f 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 01 a1 0 0 0 0 0 0 0 14 13
redsum_vl5 7 5 ff 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 01 f1 0 0 0 0 0 0 0 15 14
redsum_no0 7 8 fe 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 01 231 0 0 0 0 0 0 0 16 15
redsum_none 7 8 00 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 01 1 0 0 0 0 0 0 0 17 16
redsum_wrap 7 8 ff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff ffffffff
    5 0 0 0 0 0 0 0 01 fffffffd 0 0 0 0 0 0 0 18 17
redsum_mix 7 8 ff 5 ffffffff 7 0 80000000 9 1 64 9 1 7 3 7fffffff 2 ffffffff 63 01
    80000082 0 0 0 0 0 0 0 19 18
redsum_vl0 7 0 ff 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 01 1 0 0 0 0 0 0 0 1a 19
add_last 0 8 ff 10 20 30 40 50 60 70 80 1 2 3 4 5 6 7 8 ff 11 22 33 44 55 66 77 88 1f 1f

// File: sim/vex_tb.sv
`timescale 1ns/100ps

module vex_tb
    import vex_pkg::*;
();

    localparam int LANES     = 8;
    localparam int MAX_CASES = 64;
    localparam int TIMEOUT   = 40;

    logic                               clk;
    logic                               rst_n;
    logic                               valid_i;
    vex_lane_in_t [LANES-1:0]           lane_i;
    vex_info_t                          info_i;
    logic                               idle_o;
    logic [LANES-1:0]                   frw_a_en_o;
    logic [LANES-1:0][DATA_WIDTH-1:0]   frw_a_data_o;
    vex_tag_t                           frw_a_tag_o;
    logic [LANES-1:0]                   frw_b_en_o;
    logic [LANES-1:0][DATA_WIDTH-1:0]   frw_b_data_o;
    vex_tag_t                           frw_b_tag_o;
    logic [LANES-1:0]                   wr_en_o;
    logic [LANES-1:0][DATA_WIDTH-1:0]   wr_data_o;
    vex_tag_t                           wr_tag_o;

    // Case table
    string       c_name   [MAX_CASES];
    logic [31:0] c_op     [MAX_CASES];
    logic [31:0] c_vl     [MAX_CASES];
    logic [31:0] c_mask   [MAX_CASES];
    logic [31:0] c_en     [MAX_CASES];
    logic [31:0] c_dst    [MAX_CASES];
    logic [31:0] c_ticket [MAX_CASES];
    logic [31:0] c_a      [MAX_CASES][LANES];
    logic [31:0] c_b      [MAX_CASES][LANES];
    logic [31:0] c_res    [MAX_CASES][LANES];

    int num_cases;
    // Case index per cycle with the newest last and -1 for an idle cycle
    int sched[$];

    vex #(
        .VECTOR_LANES (LANES)
    ) vex_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .valid_i      (valid_i),
        .lane_i       (lane_i),
        .info_i       (info_i),
        .idle_o       (idle_o),
        .frw_a_en_o   (frw_a_en_o),
        .frw_a_data_o (frw_a_data_o),
        .frw_a_tag_o  (frw_a_tag_o),
        .frw_b_en_o   (frw_b_en_o),
        .frw_b_data_o (frw_b_data_o),
        .frw_b_tag_o  (frw_b_tag_o),
        .wr_en_o      (wr_en_o),
        .wr_data_o    (wr_data_o),
        .wr_tag_o     (wr_tag_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    endtask

    task automatic read_hex(input int fd, output logic [31:0] value, inout int count);
        count += $fscanf(fd, "%h", value);
    endtask

    // ------------------------------
    // Case file reader
    // ------------------------------
    task automatic read_cases();
        int    fd;
        int    n;
        int    fields;
        string word;
        string rest;
        fd = $fopen("sim/vex_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open the case file sim/vex_cases.txt");
            $display("TESTS FAILED");
            $fatal(1, "no case file");
        end else begin
            num_cases = 0;
            while (!$feof(fd)) begin
                n = $fscanf(fd, "%s", word);
                if (n == 1 && word[0] == "#") begin
                    void'($fgets(rest, fd));
                end else if (n == 1) begin
                    fields = 0;
                    c_name[num_cases] = word;
                    read_hex(fd, c_op[num_cases], fields);
                    read_hex(fd, c_vl[num_cases], fields);
                    read_hex(fd, c_mask[num_cases], fields);
                    for (int l = 0; l < LANES; l++) read_hex(fd, c_a[num_cases][l], fields);
                    for (int l = 0; l < LANES; l++) read_hex(fd, c_b[num_cases][l], fields);
                    read_hex(fd, c_en[num_cases], fields);
                    for (int l = 0; l < LANES; l++) read_hex(fd, c_res[num_cases][l], fields);
                    read_hex(fd, c_dst[num_cases], fields);
                    read_hex(fd, c_ticket[num_cases], fields);
                    if (fields != 30) begin
                        $display("case %s in the case file has missing fields", word);
                        $display("TESTS FAILED");
                        $fatal(1, "bad case file");
                    end
                    num_cases++;
                end
            end
            $fclose(fd);
        end
    endtask

    // ------------------------------
    // Drivers and per-cycle checks
    // ------------------------------
    task automatic drive_case(input int i);
        valid_i       <= 1'b1;
        info_i.op     <= vex_op_e'(c_op[i][2:0]);
        info_i.vl     <= c_vl[i][VL_BITS-1:0];
        info_i.dst    <= c_dst[i][VREG_ADDR_BITS-1:0];
        info_i.ticket <= c_ticket[i][TICKET_BITS-1:0];
        for (int l = 0; l < LANES; l++) begin
            lane_i[l].mask   <= c_mask[i][l];
            lane_i[l].data_a <= c_a[i][l];
            lane_i[l].data_b <= c_b[i][l];
        end
    endtask

    // Lane enables expected at one point; forward A never shows a reduction
    function automatic logic [LANES-1:0] expected_en(input int idx, input bit point_a);
        if (idx < 0) return '0;
        if (point_a && c_op[idx][2:0] == 3'd7) return '0;
        return c_en[idx][LANES-1:0];
    endfunction

    task automatic check_lanes(input string point, input int idx, input bit point_a,
                               input logic [LANES-1:0] en,
                               input logic [LANES-1:0][DATA_WIDTH-1:0] data,
                               input vex_tag_t tag);
        string            name;
        logic [LANES-1:0] exp_en;
        name   = (idx >= 0) ? {c_name[idx], " ", point} : {"idle ", point};
        exp_en = expected_en(idx, point_a);
        check_value({name, " en"}, 32'(exp_en), 32'(en));
        if (idx >= 0) begin
            for (int l = 0; l < LANES; l++) begin
                if (exp_en[l]) check_value({name, " data"}, c_res[idx][l], data[l]);
            end
            check_value({name, " tag"},
                        {22'b0, c_dst[idx][4:0], c_ticket[idx][4:0]}, 32'(tag));
        end
    endtask

    // Drive on the rising edge and check on the falling edge
    task automatic run_cycle(input int idx);
        logic exp_idle;
        @(posedge clk);
        if (idx >= 0) drive_case(idx);
        else valid_i <= 1'b0;
        sched.push_back(idx);
        void'(sched.pop_front());
        @(negedge clk);
        exp_idle = (sched[4] < 0) && (sched[3] < 0) && (sched[2] < 0) && (sched[1] < 0);
        check_value("idle", 32'(exp_idle), 32'(idle_o));
        check_lanes("forward a", sched[4], 1'b1, frw_a_en_o, frw_a_data_o, frw_a_tag_o);
        check_lanes("forward b", sched[1], 1'b0, frw_b_en_o, frw_b_data_o, frw_b_tag_o);
        check_lanes("writeback", sched[0], 1'b0, wr_en_o, wr_data_o, wr_tag_o);
    endtask

    function automatic bit pipe_busy();
        foreach (sched[k]) begin
            if (sched[k] >= 0) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic wait_idle(input string what);
        int cnt;
        cnt = 0;
        while (!idle_o || pipe_busy()) begin
            if (cnt >= TIMEOUT) stop_on_timeout(what);
            run_cycle(-1);
            cnt++;
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        rst_n       = 1'b0;
        valid_i     = 1'b0;
        lane_i      = '0;
        info_i      = '0;
        for (int k = 0; k < 5; k++) sched.push_back(-1);
        read_cases();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // Idle high and every enable low right after reset
        run_cycle(-1);

        // First half back to back, then with idle gaps
        for (int i = 0; i < num_cases; i++) begin
            if (i >= num_cases / 2) begin
                for (int g = 0; g < i % 4; g++) run_cycle(-1);
            end
            run_cycle(i);
        end
        wait_idle("pipeline drain");
        run_cycle(-1);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: source/vex.sv
`timescale 1ns/100ps

module vex
    import vex_pkg::*;
#(
    parameter int VECTOR_LANES = 8
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     valid_i,
    input  vex_lane_in_t [VECTOR_LANES-1:0]          lane_i,
    input  vex_info_t                                info_i,
    output logic                                     idle_o,
    // Forward point A (EX1)
    output logic [VECTOR_LANES-1:0]                  frw_a_en_o,
    output logic [VECTOR_LANES-1:0][DATA_WIDTH-1:0]  frw_a_data_o,
    output vex_tag_t                                 frw_a_tag_o,
    // Forward point B (EX4)
    output logic [VECTOR_LANES-1:0]                  frw_b_en_o,
    output logic [VECTOR_LANES-1:0][DATA_WIDTH-1:0]  frw_b_data_o,
    output vex_tag_t                                 frw_b_tag_o,
    // Writeback
    output logic [VECTOR_LANES-1:0]                  wr_en_o,
    output logic [VECTOR_LANES-1:0][DATA_WIDTH-1:0]  wr_data_o,
    output vex_tag_t                                 wr_tag_o
);

    logic [VECTOR_LANES-1:0][DATA_WIDTH-1:0] rdc_ex1_in;
    logic [VECTOR_LANES-1:0][DATA_WIDTH-1:0] rdc_ex1_out;
    logic [VECTOR_LANES-1:0][DATA_WIDTH-1:0] rdc_ex2_in;
    logic [VECTOR_LANES-1:0][DATA_WIDTH-1:0] rdc_ex2_out;
    logic [VECTOR_LANES-1:0][DATA_WIDTH-1:0] rdc_ex3_in;
    logic [VECTOR_LANES-1:0][DATA_WIDTH-1:0] rdc_ex3_out;

    // ------------------------------
    // Lanes
    // ------------------------------
    for (genvar k = 0; k < VECTOR_LANES; k++) begin : g_lane
        vex_lane #(
            .VECTOR_LANES (VECTOR_LANES),
            .LANE_NUM     (k)
        ) vex_lane_i (
            .clk          (clk),
            .rst_n        (rst_n),
            .valid_i      (valid_i),
            .lane_i       (lane_i[k]),
            .op_i         (info_i.op),
            .vl_i         (info_i.vl),
            .rdc_ex1_i    (rdc_ex1_in[k]),
            .rdc_ex2_i    (rdc_ex2_in[k]),
            .rdc_ex3_i    (rdc_ex3_in[k]),
            .rdc_ex1_o    (rdc_ex1_out[k]),
            .rdc_ex2_o    (rdc_ex2_out[k]),
            .rdc_ex3_o    (rdc_ex3_out[k]),
            .frw_a_en_o   (frw_a_en_o[k]),
            .frw_a_data_o (frw_a_data_o[k]),
            .frw_b_en_o   (frw_b_en_o[k]),
            .frw_b_data_o (frw_b_data_o[k]),
            .wr_en_o      (wr_en_o[k]),
            .wr_data_o    (wr_data_o[k])
        );
    end

    // ------------------------------
    // Reduction tree
    // ------------------------------
    // Round 1, pairs of neighbours, summed into EX2
    for (genvar k = 0; k < VECTOR_LANES; k++) begin : g_rdc_r1
        if ((k % 2 == 0) && (k + 1 < VECTOR_LANES)) begin : g_link
            assign rdc_ex1_in[k] = rdc_ex1_out[k+1];
        end else begin : g_none
            assign rdc_ex1_in[k] = '0;
        end
    end

    // Round 2, stride 2, summed into EX3
    for (genvar k = 0; k < VECTOR_LANES; k++) begin : g_rdc_r2
        if ((VECTOR_LANES > 2) && (k % 4 == 0) && (k + 2 < VECTOR_LANES)) begin : g_link
            assign rdc_ex2_in[k] = rdc_ex2_out[k+2];
        end else begin : g_none
            assign rdc_ex2_in[k] = '0;
        end
    end

    // Round 3, stride 4, summed into EX4
    for (genvar k = 0; k < VECTOR_LANES; k++) begin : g_rdc_r3
        if ((VECTOR_LANES > 4) && (k % 8 == 0) && (k + 4 < VECTOR_LANES)) begin : g_link
            assign rdc_ex3_in[k] = rdc_ex3_out[k+4];
        end else begin : g_none
            assign rdc_ex3_in[k] = '0;
        end
    end

    // ------------------------------
    // Control
    // ------------------------------
    vex_ctrl_pipe vex_ctrl_pipe_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .valid_i     (valid_i),
        .info_i      (info_i),
        .frw_a_tag_o (frw_a_tag_o),
        .frw_b_tag_o (frw_b_tag_o),
        .wr_tag_o    (wr_tag_o),
        .idle_o      (idle_o)
    );

endmodule

// File: source/vex_ctrl_pipe.sv
`timescale 1ns/100ps

module vex_ctrl_pipe
    import vex_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      valid_i,
    input  vex_info_t info_i,
    output vex_tag_t  frw_a_tag_o,
    output vex_tag_t  frw_b_tag_o,
    output vex_tag_t  wr_tag_o,
    output logic      idle_o
);

    logic     valid_ex2;
    logic     valid_ex3;
    logic     valid_ex4;
    vex_tag_t tag_ex1;
    vex_tag_t tag_ex2;
    vex_tag_t tag_ex3;
    vex_tag_t tag_ex4;
    vex_tag_t tag_wr;

    assign tag_ex1.dst    = info_i.dst;
    assign tag_ex1.ticket = info_i.ticket;

    // ------------------------------
    // Valid bits
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_ex2 <= 1'b0;
            valid_ex3 <= 1'b0;
            valid_ex4 <= 1'b0;
        end else begin
            valid_ex2 <= valid_i;
            valid_ex3 <= valid_ex2;
            valid_ex4 <= valid_ex3;
        end
    end

    // ------------------------------
    // Tags, moved only with a valid micro-op
    // ------------------------------
    always_ff @(posedge clk) begin
        if (valid_i) begin
            tag_ex2 <= tag_ex1;
        end
        if (valid_ex2) begin
            tag_ex3 <= tag_ex2;
        end
        if (valid_ex3) begin
            tag_ex4 <= tag_ex3;
        end
        if (valid_ex4) begin
            tag_wr <= tag_ex4;
        end
    end

    assign frw_a_tag_o = tag_ex1;
    assign frw_b_tag_o = tag_ex4;
    assign wr_tag_o    = tag_wr;

    // Nothing between EX1 and EX4
    assign idle_o = ~valid_i & ~valid_ex2 & ~valid_ex3 & ~valid_ex4;

endmodule

// File: source/vex_lane.sv
`timescale 1ns/100ps

module vex_lane
    import vex_pkg::*;
#(
    parameter int VECTOR_LANES = 8,
    parameter int LANE_NUM     = 0
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  valid_i,
    input  vex_lane_in_t          lane_i,
    input  vex_op_e               op_i,
    input  logic [VL_BITS-1:0]    vl_i,
    // Reduction tree partner inputs
    input  logic [DATA_WIDTH-1:0] rdc_ex1_i,
    input  logic [DATA_WIDTH-1:0] rdc_ex2_i,
    input  logic [DATA_WIDTH-1:0] rdc_ex3_i,
    // Reduction tree taps offered to other lanes
    output logic [DATA_WIDTH-1:0] rdc_ex1_o,
    output logic [DATA_WIDTH-1:0] rdc_ex2_o,
    output logic [DATA_WIDTH-1:0] rdc_ex3_o,
    // Forward point A (EX1)
    output logic                  frw_a_en_o,
    output logic [DATA_WIDTH-1:0] frw_a_data_o,
    // Forward point B (EX4)
    output logic                  frw_b_en_o,
    output logic [DATA_WIDTH-1:0] frw_b_data_o,
    // Writeback
    output logic                  wr_en_o,
    output logic [DATA_WIDTH-1:0] wr_data_o
);

    // Role of this lane in each reduction round
    localparam bit ROOT     = (LANE_NUM == 0);
    localparam bit TAKES_R1 = (LANE_NUM % 2 == 0) && (LANE_NUM + 1 < VECTOR_LANES);
    localparam bit TAKES_R2 = (LANE_NUM % 4 == 0) && (LANE_NUM + 2 < VECTOR_LANES);
    localparam bit TAKES_R3 = (LANE_NUM % 8 == 0) && (LANE_NUM + 4 < VECTOR_LANES);

    logic                  active;
    logic                  is_rdc;
    logic                  en_ex1;
    logic [DATA_WIDTH-1:0] elem_res;
    logic [DATA_WIDTH-1:0] seed;
    logic [DATA_WIDTH-1:0] part_r1;
    logic [DATA_WIDTH-1:0] part_r2;
    logic [DATA_WIDTH-1:0] part_r3;

    logic                  en_ex2;
    logic                  en_ex3;
    logic                  en_ex4;
    logic                  rdc_op_ex2;
    logic                  rdc_op_ex3;
    logic [DATA_WIDTH-1:0] data_ex2;
    logic [DATA_WIDTH-1:0] data_ex3;
    logic [DATA_WIDTH-1:0] data_ex4;

    // ------------------------------
    // EX1
    // ------------------------------
    assign active = lane_i.mask && (VL_BITS'(LANE_NUM) < vl_i);
    assign is_rdc = (op_i == op_redsum);

    always_comb begin
        case (op_i)
            op_add:  elem_res = lane_i.data_a + lane_i.data_b;
            op_sub:  elem_res = lane_i.data_a - lane_i.data_b;
            op_and:  elem_res = lane_i.data_a & lane_i.data_b;
            op_or:   elem_res = lane_i.data_a | lane_i.data_b;
            op_xor:  elem_res = lane_i.data_a ^ lane_i.data_b;
            op_minu: elem_res = (lane_i.data_a < lane_i.data_b) ? lane_i.data_a : lane_i.data_b;
            op_maxu: elem_res = (lane_i.data_a > lane_i.data_b) ? lane_i.data_a : lane_i.data_b;
            default: elem_res = '0;
        endcase
    end

    // Inactive lanes contribute nothing, lane 0 also brings data_b
    assign seed = (active ? lane_i.data_a : '0) + (ROOT ? lane_i.data_b : '0);

    assign frw_a_en_o   = valid_i & active & ~is_rdc;
    assign frw_a_data_o = elem_res;

    // Reduction result only shows on lane 0
    assign en_ex1 = is_rdc ? (valid_i & ROOT) : (valid_i & active);

    // Partner sums, zero where this lane has no partner
    assign part_r1 = TAKES_R1 ? rdc_ex1_i : '0;
    assign part_r2 = TAKES_R2 ? rdc_ex2_i : '0;
    assign part_r3 = TAKES_R3 ? rdc_ex3_i : '0;

    assign rdc_ex1_o = seed;
    assign rdc_ex2_o = data_ex2;
    assign rdc_ex3_o = data_ex3;

    // ------------------------------
    // EX2 to writeback
    // ------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            en_ex2     <= 1'b0;
            en_ex3     <= 1'b0;
            en_ex4     <= 1'b0;
            wr_en_o    <= 1'b0;
            rdc_op_ex2 <= 1'b0;
            rdc_op_ex3 <= 1'b0;
        end else begin
            en_ex2     <= en_ex1;
            en_ex3     <= en_ex2;
            en_ex4     <= en_ex3;
            wr_en_o    <= en_ex4;
            rdc_op_ex2 <= valid_i & is_rdc;
            rdc_op_ex3 <= rdc_op_ex2;
        end
    end

    // Element result or running partial sum
    always_ff @(posedge clk) begin
        data_ex2  <= is_rdc ? (seed + part_r1) : elem_res;
        data_ex3  <= rdc_op_ex2 ? (data_ex2 + part_r2) : data_ex2;
        data_ex4  <= rdc_op_ex3 ? (data_ex3 + part_r3) : data_ex3;
        wr_data_o <= data_ex4;
    end

    assign frw_b_en_o   = en_ex4;
    assign frw_b_data_o = data_ex4;

endmodule

// File: source/vex_pkg.sv
package vex_pkg;

    // Element and control widths
    localparam int DATA_WIDTH     = 32;
    localparam int VREG_ADDR_BITS = 5;
    localparam int TICKET_BITS    = 5;
    localparam int VL_BITS        = 4;

    // Micro-op encoding
    typedef enum logic [2:0] {
        op_add    = 3'd0,
        op_sub    = 3'd1,
        op_and    = 3'd2,
        op_or     = 3'd3,
        op_xor    = 3'd4,
        op_minu   = 3'd5,
        op_maxu   = 3'd6,
        op_redsum = 3'd7
    } vex_op_e;

    // Per-lane operands
    typedef struct packed {
        logic                  mask;
        logic [DATA_WIDTH-1:0] data_a;
        logic [DATA_WIDTH-1:0] data_b;
    } vex_lane_in_t;

    // Shared micro-op information
    typedef struct packed {
        vex_op_e                   op;
        logic [VL_BITS-1:0]        vl;
        logic [VREG_ADDR_BITS-1:0] dst;
        logic [TICKET_BITS-1:0]    ticket;
    } vex_info_t;

    // Destination and ordering tag of a result
    typedef struct packed {
        logic [VREG_ADDR_BITS-1:0] dst;
        logic [TICKET_BITS-1:0]    ticket;
    } vex_tag_t;

endpackage

// File: vex.f
source/vex_pkg.sv
source/vex_lane.sv
source/vex_ctrl_pipe.sv
source/vex.sv
sim/vex_tb.sv
